// ==== src/dma_pkg.sv ====
// Shared types for the data mover; only dc bits 8 to 10 carry commands, the rest are reserved
`default_nettype none

package dma_pkg;

   localparam int DC_W   = 24;                 // Command word width
   localparam int DATA_W = 64;                 // Payload width of one packet word

   // Command bit positions, lowest set bit wins
   localparam int OP_READ_BIT = 8;             // Drain and discard
   localparam int OP_COPY_BIT = 9;             // Source to destination
   localparam int OP_CSUM_BIT = 10;            // XOR of packet to destination

   // One packet word as stored in a FIFO
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;                 // Final word of the packet
   } data_word_t;

   // Level flags of one FIFO
   typedef struct packed {
      logic empty;
      logic almost_empty;                      // Exactly one word held
      logic full;
      logic almost_full;                       // One slot left
   } fifo_stat_t;

   // What an operation asks of the shared FIFO ports, all strobes active low
   typedef struct packed {
      logic       getn;                        // Pop source FIFO
      logic       putn;                        // Push destination FIFO
      data_word_t dst;                         // Word to push
      logic       endn;                        // Operation finished
   } op_req_t;

   // Request of an operation that does nothing
   localparam op_req_t OP_REQ_IDLE = '{
      getn: 1'b1,
      putn: 1'b1,
      dst:  '0,
      endn: 1'b1
   };

endpackage

`default_nettype wire

// ==== src/word_fifo.sv ====
// First-word-fall-through FIFO; DEPTH must be a power of two of at least 4, writes when full and reads when empty are dropped
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
   parameter int DEPTH = 16
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      we,
   input  wire dma_pkg::data_word_t wdata,
   input  wire                      re,
   output dma_pkg::data_word_t      rdata,
   output dma_pkg::fifo_stat_t      stat
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] CNT_FULL  = (AW+1)'(DEPTH);
   localparam logic [AW:0] CNT_AFULL = (AW+1)'(DEPTH - 1);

   dma_pkg::data_word_t mem [DEPTH];          // Storage, no reset

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;                       // One extra bit to hold DEPTH
   logic          do_wr;
   logic          do_rd;

   assign do_wr = we && !stat.full;            // Drop writes when full
   assign do_rd = re && !stat.empty;           // Drop reads when empty

   // Head word is always visible
   assign rdata = mem[rd_ptr];

   assign stat.empty        = (count == '0);
   assign stat.almost_empty = (count == (AW+1)'(1));
   assign stat.full         = (count == CNT_FULL);
   assign stat.almost_full  = (count == CNT_AFULL);

   always_ff @(posedge wb_clk_i) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;           // Wraps at DEPTH
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/op_read.sv ====
// Drains one source packet and discards it; leaving END needs enable to drop
`timescale 1ns/1ps
`default_nettype none

module op_read (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      enable,
   input  wire dma_pkg::data_word_t src,
   input  wire dma_pkg::fifo_stat_t src_stat,
   output dma_pkg::op_req_t         req
);

   typedef enum logic [1:0] {
      S_IDLE = 2'b00,
      S_RUN  = 2'b01,
      S_WAIT = 2'b10,
      S_END  = 2'b11
   } state_t;

   state_t state;
   state_t state_n;
   logic   pop;

   // Pop whenever a word is there, in RUN or WAIT
   assign pop = enable && (state == S_RUN || state == S_WAIT) && !src_stat.empty;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= S_IDLE;
      end else begin
         state <= state_n;
      end
   end

   always_comb begin
      state_n = state;
      if (!enable) begin
         state_n = S_IDLE;                     // Command withdrawn
      end else begin
         case (state)
            S_IDLE:        if (!src_stat.empty) state_n = S_RUN;
            S_RUN, S_WAIT: begin
               if (pop && src.last) begin
                  state_n = S_END;
               end else if (src_stat.empty) begin
                  state_n = S_WAIT;
               end else begin
                  state_n = S_RUN;
               end
            end
            default:       state_n = S_END;    // Hold until enable drops
         endcase
      end
   end

   assign req.getn = !pop;
   assign req.putn = 1'b1;                     // Never pushes
   assign req.dst  = '0;
   assign req.endn = (state != S_END);

endmodule

`default_nettype wire

// ==== src/op_copy.sv ====
// Copies one packet from source to destination, one word per cycle at most; a full destination stalls the pop too
`timescale 1ns/1ps
`default_nettype none

module op_copy (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      enable,
   input  wire dma_pkg::data_word_t src,
   input  wire dma_pkg::fifo_stat_t src_stat,
   input  wire dma_pkg::fifo_stat_t dst_stat,
   output dma_pkg::op_req_t         req
);

   typedef enum logic [1:0] {
      S_IDLE = 2'b00,
      S_RUN  = 2'b01,
      S_WAIT = 2'b10,
      S_END  = 2'b11
   } state_t;

   state_t state;
   state_t state_n;
   logic   running;
   logic   move;

   assign running = enable && (state == S_RUN || state == S_WAIT);

   // Pop and push together, only when both sides allow it
   assign move = running && !src_stat.empty && !dst_stat.full;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= S_IDLE;
      end else begin
         state <= state_n;
      end
   end

   always_comb begin
      state_n = state;
      if (!enable) begin
         state_n = S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (!src_stat.empty) begin
                  state_n = S_RUN;
               end
            end
            S_RUN, S_WAIT: begin
               if (move && src.last) begin
                  state_n = S_END;             // Last word went out
               end else if (src_stat.empty) begin
                  state_n = S_WAIT;
               end else begin
                  state_n = S_RUN;             // Stays here under back-pressure
               end
            end
            default: state_n = S_END;
         endcase
      end
   end

   assign req.getn = !move;
   assign req.putn = !move;
   assign req.dst  = src;                      // Last flag passes through
   assign req.endn = (state != S_END);

endmodule

`default_nettype wire

// ==== src/op_checksum.sv ====
// XORs one packet into a single result word marked last; the result waits in PUSH while the destination is full
`timescale 1ns/1ps
`default_nettype none

module op_checksum (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      enable,
   input  wire dma_pkg::data_word_t src,
   input  wire dma_pkg::fifo_stat_t src_stat,
   input  wire dma_pkg::fifo_stat_t dst_stat,
   output dma_pkg::op_req_t         req
);

   typedef enum logic [2:0] {
      S_IDLE = 3'd0,
      S_RUN  = 3'd1,
      S_WAIT = 3'd2,
      S_PUSH = 3'd3,
      S_END  = 3'd4
   } state_t;

   state_t                      state;
   state_t                      state_n;
   logic [dma_pkg::DATA_W-1:0] acc;            // Running XOR
   logic                        pop;
   logic                        push;

   assign pop  = enable && (state == S_RUN || state == S_WAIT) && !src_stat.empty;
   assign push = enable && (state == S_PUSH) && !dst_stat.full;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= S_IDLE;
      end else begin
         state <= state_n;
      end
   end

   // Cleared every cycle spent in IDLE
   always_ff @(posedge wb_clk_i) begin
      if (state == S_IDLE) begin
         acc <= '0;
      end else if (pop) begin
         acc <= acc ^ src.data;
      end
   end

   always_comb begin
      state_n = state;
      if (!enable) begin
         state_n = S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (!src_stat.empty) begin
                  state_n = S_RUN;
               end
            end
            S_RUN, S_WAIT: begin
               if (pop && src.last) begin
                  state_n = S_PUSH;            // Acc complete next cycle
               end else if (src_stat.empty) begin
                  state_n = S_WAIT;
               end else begin
                  state_n = S_RUN;
               end
            end
            S_PUSH:  if (push) state_n = S_END;
            default: state_n = S_END;
         endcase
      end
   end

   assign req.getn      = !pop;
   assign req.putn      = !push;
   assign req.dst.data  = acc;
   assign req.dst.last  = 1'b1;                // Result is a one-word packet
   assign req.endn      = (state != S_END);

endmodule

`default_nettype wire

// ==== src/fifo_port_arbiter.sv ====
// Grants the FIFO ports to the lowest set command bit among 8 to 10; other dc bits are ignored
`timescale 1ns/1ps
`default_nettype none

module fifo_port_arbiter (
   input  wire [dma_pkg::DC_W-1:0] dc,
   input  wire dma_pkg::op_req_t   read_req,
   input  wire dma_pkg::op_req_t   copy_req,
   input  wire dma_pkg::op_req_t   csum_req,
   output logic                    read_en,
   output logic                    copy_en,
   output logic                    csum_en,
   output logic                    src_re,
   output logic                    dst_we,
   output dma_pkg::data_word_t     dst_wdata,
   output logic                    endn
);

   logic [2:0]       grant;                    // One-hot, bit 0 is read
   dma_pkg::op_req_t sel;

   // Priority: read over copy over checksum
   always_comb begin
      grant = 3'b000;
      if (dc[dma_pkg::OP_READ_BIT]) begin
         grant = 3'b001;
      end else if (dc[dma_pkg::OP_COPY_BIT]) begin
         grant = 3'b010;
      end else if (dc[dma_pkg::OP_CSUM_BIT]) begin
         grant = 3'b100;
      end
   end

   assign read_en = grant[0];
   assign copy_en = grant[1];
   assign csum_en = grant[2];

   // Requests of ungranted operations never reach the FIFOs
   always_comb begin
      case (grant)
         3'b001:  sel = read_req;
         3'b010:  sel = copy_req;
         3'b100:  sel = csum_req;
         default: sel = dma_pkg::OP_REQ_IDLE;  // No command
      endcase
   end

   // Active-low strobes become the FIFOs' active-high ones
   assign src_re    = !sel.getn;
   assign dst_we    = !sel.putn;
   assign dst_wdata = sel.dst;
   assign endn      = sel.endn;

endmodule

`default_nettype wire

// ==== src/dma_engine_top.sv ====
// Data mover top; dc must be held for the whole operation and dropped after endn falls
`timescale 1ns/1ps
`default_nettype none

module dma_engine_top #(
   parameter int FIFO_DEPTH = 16               // Power of two, at least 4
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      src_we,
   input  wire dma_pkg::data_word_t src_in,
   output logic                     src_full,
   input  wire                      dst_re,
   output dma_pkg::data_word_t      dst_out,
   output logic                     dst_empty,
   input  wire [dma_pkg::DC_W-1:0]  dc,
   output logic                     endn
);

   dma_pkg::data_word_t src_head;
   dma_pkg::fifo_stat_t src_stat;
   dma_pkg::fifo_stat_t dst_stat;
   dma_pkg::data_word_t dst_wdata;
   dma_pkg::op_req_t    read_req;
   dma_pkg::op_req_t    copy_req;
   dma_pkg::op_req_t    csum_req;
   logic                src_re;
   logic                dst_we;
   logic                read_en;
   logic                copy_en;
   logic                csum_en;

   assign src_full  = src_stat.full;
   assign dst_empty = dst_stat.empty;

   word_fifo #(.DEPTH(FIFO_DEPTH)) u_src_fifo (
      .wb_clk_i, .wb_rst_i,
      .we(src_we), .wdata(src_in), .re(src_re),
      .rdata(src_head), .stat(src_stat)
   );

   word_fifo #(.DEPTH(FIFO_DEPTH)) u_dst_fifo (
      .wb_clk_i, .wb_rst_i,
      .we(dst_we), .wdata(dst_wdata), .re(dst_re),
      .rdata(dst_out), .stat(dst_stat)
   );

   op_read u_read (
      .wb_clk_i, .wb_rst_i, .enable(read_en),
      .src(src_head), .src_stat, .req(read_req)
   );

   op_copy u_copy (
      .wb_clk_i, .wb_rst_i, .enable(copy_en),
      .src(src_head), .src_stat, .dst_stat, .req(copy_req)
   );

   op_checksum u_csum (
      .wb_clk_i, .wb_rst_i, .enable(csum_en),
      .src(src_head), .src_stat, .dst_stat, .req(csum_req)
   );

   fifo_port_arbiter u_arb (
      .dc, .read_req, .copy_req, .csum_req,
      .read_en, .copy_en, .csum_en,
      .src_re, .dst_we, .dst_wdata, .endn
   );

endmodule

`default_nettype wire

// ==== test/dma_checker.sv ====
// Watches the destination read side, endn and src_full; expected words are queued by the testbench before each test
`timescale 1ns/1ps
`default_nettype none

module dma_checker (
   input wire                      wb_clk_i,
   input wire                      wb_rst_i,
   input wire                      src_full,
   input wire                      dst_re,
   input wire                      dst_empty,
   input wire dma_pkg::data_word_t dst_out,
   input wire                      endn
);

   dma_pkg::data_word_t exp_q [$];             // Words still to come out
   dma_pkg::data_word_t want;
   int   errors      = 0;
   int   test_errors = 0;
   int   tests_run   = 0;
   int   end_falls   = 0;                      // Falling edges of endn in this test
   logic endn_q      = 1'b1;

   task automatic expect_word(input dma_pkg::data_word_t w);
      exp_q.push_back(w);
   endtask

   task automatic report(input string msg);
      $display("time %0t: %s", $time, msg);
      errors++;
      test_errors++;
   endtask

   // Compares one flag against the level it must have
   task automatic check_level(input string sig, input logic got, input logic exp_v);
      if (got !== exp_v) begin
         $display("MISMATCH time %0t: %s got %b expected %b", $time, sig, got, exp_v);
         errors++;
         test_errors++;
      end
   endtask

   // Engine with no command and empty FIFOs
   task automatic check_idle();
      check_level("endn", endn, 1'b1);
      check_level("dst_empty", dst_empty, 1'b1);
      check_level("src_full", src_full, 1'b0);
   endtask

   // Anything left over counts against the test
   task automatic end_test(input string name, input int ends_expected);
      if (exp_q.size() != 0) begin
         report($sformatf("%0d expected destination words never arrived", exp_q.size()));
      end
      if (end_falls != ends_expected) begin
         report($sformatf("endn fell %0d times, expected %0d", end_falls, ends_expected));
      end
      $display("test %s %s", name, (test_errors == 0) ? "ok" : "failed");
      tests_run++;
      test_errors = 0;
      end_falls   = 0;
      exp_q.delete();
   endtask

   // Sampled mid-cycle so a pop lands on the next rising edge
   always @(negedge wb_clk_i) begin
      if (wb_rst_i) begin
         endn_q = 1'b1;
      end else begin
         if (endn_q && !endn) begin
            end_falls++;
         end
         endn_q = endn;
         if (dst_re && !dst_empty) begin
            if (exp_q.size() == 0) begin
               report("destination held a word that no operation should have produced");
            end else begin
               want = exp_q.pop_front();
               if (dst_out.data !== want.data) begin
                  $display("MISMATCH time %0t: dst_out.data got %h expected %h",
                           $time, dst_out.data, want.data);
                  errors++;
                  test_errors++;
               end
               if (dst_out.last !== want.last) begin
                  $display("MISMATCH time %0t: dst_out.last got %b expected %b",
                           $time, dst_out.last, want.last);
                  errors++;
                  test_errors++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_dma.sv ====
// Testbench top for the data mover; FIFO depth 16 and random packets of 1 to 12 words from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_dma;

   localparam int FIFO_DEPTH   = 16;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS    = 6;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + 200 * NUM_TESTS;

   logic                      wb_clk_i = 1'b0;
   logic                      wb_rst_i;
   logic                      src_we;
   dma_pkg::data_word_t       src_in;
   logic                      src_full;
   logic                      dst_re;
   dma_pkg::data_word_t       dst_out;
   logic                      dst_empty;
   logic [dma_pkg::DC_W-1:0]  dc;
   logic                      endn;
   logic [31:0]               lcg_state = 32'd30;
   logic [63:0]               pkt [$];        // Current packet payload
   int                        cycles = 0;

   always #5 wb_clk_i = ~wb_clk_i;

   dma_engine_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
      .wb_clk_i, .wb_rst_i, .src_we, .src_in, .src_full,
      .dst_re, .dst_out, .dst_empty, .dc, .endn
   );

   dma_checker chk (
      .wb_clk_i, .wb_rst_i, .src_full, .dst_re, .dst_empty, .dst_out, .endn
   );

   always @(posedge wb_clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Expected destination word idx of an operation on the current packet
   function automatic dma_pkg::data_word_t ref_word(input int op, input int idx);
      dma_pkg::data_word_t w;
      logic [63:0]         x;
      x = '0;
      if (op == dma_pkg::OP_CSUM_BIT) begin
         foreach (pkt[i]) x = x ^ pkt[i];
         w.data = x;
         w.last = 1'b1;
      end else begin
         w.data = pkt[idx];
         w.last = (idx == pkt.size() - 1);
      end
      return w;
   endfunction

   // One word per two cycles and none while the source is full
   task automatic load_packet();
      int i;
      i = 0;
      while (i < pkt.size()) begin
         @(negedge wb_clk_i);
         if (!src_full) begin
            @(posedge wb_clk_i);
            src_we      <= 1'b1;
            src_in.data <= pkt[i];
            src_in.last <= (i == pkt.size() - 1);
            @(posedge wb_clk_i);
            src_we      <= 1'b0;
            i++;
         end
      end
   endtask

   task automatic run_op(input string name, input logic [dma_pkg::DC_W-1:0] cmd,
                         input int op, input int len, input bit stall);
      int n_exp;
      pkt.delete();
      for (int i = 0; i < len; i++) begin
         pkt.push_back({lcg_next(), lcg_next()});
      end
      n_exp = (op == dma_pkg::OP_READ_BIT) ? 0 : (op == dma_pkg::OP_CSUM_BIT) ? 1 : len;
      for (int i = 0; i < n_exp; i++) begin
         chk.expect_word(ref_word(op, i));
      end
      @(posedge wb_clk_i);
      dc     <= cmd;
      dst_re <= !stall;
      load_packet();
      if (stall) begin
         repeat (8) @(negedge wb_clk_i);      // Destination fills up and the source holds the rest
         chk.check_level("endn", endn, 1'b1);
         @(posedge wb_clk_i);
         dst_re <= 1'b1;
      end
      do @(negedge wb_clk_i); while (endn || !dst_empty);
      @(posedge wb_clk_i);
      dc     <= '0;
      dst_re <= 1'b0;
      @(posedge wb_clk_i);
      chk.end_test(name, 1);
   endtask

   initial begin
      wb_rst_i = 1'b1;
      src_we   = 1'b0;
      src_in   = '0;
      dst_re   = 1'b0;
      dc       = '0;
      repeat (RESET_CYCLES / 2) @(negedge wb_clk_i);
      chk.check_idle();
      repeat (RESET_CYCLES / 2) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      repeat (2) @(negedge wb_clk_i);
      chk.check_idle();
      @(posedge wb_clk_i);
      chk.end_test("reset", 0);

      run_op("read", 24'h1 << dma_pkg::OP_READ_BIT, dma_pkg::OP_READ_BIT,
             (lcg_next() >> 16) % 12 + 1, 1'b0);
      run_op("copy", 24'h1 << dma_pkg::OP_COPY_BIT, dma_pkg::OP_COPY_BIT,
             (lcg_next() >> 16) % 12 + 1, 1'b0);
      run_op("checksum", 24'h1 << dma_pkg::OP_CSUM_BIT, dma_pkg::OP_CSUM_BIT,
             (lcg_next() >> 16) % 12 + 1, 1'b0);
      run_op("backpressure", 24'h1 << dma_pkg::OP_COPY_BIT, dma_pkg::OP_COPY_BIT,
             FIFO_DEPTH + 4, 1'b1);
      // Copy outranks checksum
      run_op("priority", (24'h1 << dma_pkg::OP_COPY_BIT) | (24'h1 << dma_pkg::OP_CSUM_BIT),
             dma_pkg::OP_COPY_BIT, (lcg_next() >> 16) % 12 + 1, 1'b0);

      $display("%0d tests run, %0d errors", chk.tests_run, chk.errors);
      if (chk.errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
src/dma_pkg.sv
src/word_fifo.sv
src/op_read.sv
src/op_copy.sv
src/op_checksum.sv
src/fifo_port_arbiter.sv
src/dma_engine_top.sv
test/dma_checker.sv
test/tb_dma.sv

// ==== Makefile ====
# Verilator build and run of the data mover testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_dma \
		-f list.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
